/* Makefile */
# Verilator build and run of the TCB-Lite memory target testbench.
# The simulation exit status carries pass or fail.

VERILATOR ?= verilator
TOP       ?= tcb_lite_mem_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* src/tcb_lite_decode.sv */
/*
 * Request decoder of the TCB-Lite memory target.
 * Purely combinational, turns a bus request into word index, lane,
 * byte count, split flag and error for the execute stage.
 */

`timescale 1ns/1ps

`include "tcb_lite_params.svh"

module tcb_lite_decode (
    input  tcb_lite_pkg::tcb_req_t req,
    output tcb_lite_pkg::dec_op_t  op
);

    ////////////////////////////////////////
    // constants
    ////////////////////////////////////////

    // first address past the memory, one bit wider than the bus address
    localparam logic [`TCB_ADR_W:0] MEM_END = `TCB_MEM_BYTES;

    // largest legal size code for this data width
    localparam tcb_lite_pkg::siz_t SIZ_MAX = 2'd2;

    ////////////////////////////////////////
    // internal signals
    ////////////////////////////////////////

    tcb_lite_pkg::lane_t lane;
    tcb_lite_pkg::cnt_t  cnt;

    // lane plus count, max 3 + 4
    logic [2:0] lane_end;

    // address of the byte after the transfer, no overflow
    logic [`TCB_ADR_W:0] adr_end;

    logic siz_bad;
    logic rng_bad;

    ////////////////////////////////////////
    // field extraction
    ////////////////////////////////////////

    // low two address bits pick the lane
    assign lane = req.adr[1:0];

    // byte count from size code
    always_comb begin
        case (req.siz)
            2'd0:    cnt = 3'd1;
            2'd1:    cnt = 3'd2;
            2'd2:    cnt = 3'd4;
            // illegal, flagged as error below
            default: cnt = 3'd4;
        endcase
    end

    assign lane_end = 3'(lane) + cnt;
    assign adr_end  = {1'b0, req.adr} + (`TCB_ADR_W+1)'(cnt);

    ////////////////////////////////////////
    // error rules
    ////////////////////////////////////////

    assign siz_bad = (req.siz > SIZ_MAX);
    // any byte at or above the memory end
    assign rng_bad = (adr_end > MEM_END);

    ////////////////////////////////////////
    // decoded operation
    ////////////////////////////////////////

    always_comb begin
        op.wen   = req.wen;
        // word index sits right above the lane bits
        op.wrd   = req.adr[`TCB_WRD_W+1:2];
        op.lane  = lane;
        op.cnt   = cnt;
        // crosses into the next word
        op.split = (lane_end > 3'd4);
        op.err   = siz_bad | rng_bad;
        op.wdt   = req.wdt;
    end

endmodule

/* src/tcb_lite_execute.sv */
/*
 * Execute stage of the TCB-Lite memory target.
 * Holds the memory array, sequences split accesses over two cycles,
 * drives ready and registers the read words for the result stage.
 */

`timescale 1ns/1ps

`include "tcb_lite_params.svh"

module tcb_lite_execute (
    input  logic                   tcb,
    input  logic                   rst,
    input  logic                   vld,
    input  tcb_lite_pkg::dec_op_t  op,
    output logic                   rdy,
    output tcb_lite_pkg::exe_res_t res
);

    localparam int WORDS = `TCB_MEM_BYTES / (`TCB_DAT_W / 8);
    localparam int BYT   = `TCB_DAT_W / 8;

    ////////////////////////////////////////
    // internal signals
    ////////////////////////////////////////

    tcb_lite_pkg::dat_t   mem [0:WORDS-1];
    tcb_lite_pkg::phase_t phase;

    logic stall;
    logic hsk;
    // memory touched this cycle
    logic acc;
    logic sel_hi;

    tcb_lite_pkg::wrd_t wrd;

    // lane mask and shifted data over two words
    logic [2*BYT-1:0]        dbl_msk;
    logic [2*`TCB_DAT_W-1:0] dbl_wdt;

    ////////////////////////////////////////
    // handshake and phase
    ////////////////////////////////////////

    // back-pressure only in first half of a good split
    assign stall = vld & ~op.err & op.split & (phase == tcb_lite_pkg::PH_FIRST);
    assign rdy   = ~stall;
    assign hsk   = vld & rdy;
    // every valid cycle without error is either a stall or a handshake
    assign acc   = vld & ~op.err;

    always_ff @(posedge tcb) begin
        if (rst) begin
            phase <= tcb_lite_pkg::PH_FIRST;
        end else if (stall) begin
            phase <= tcb_lite_pkg::PH_SECOND;
        end else if (hsk) begin
            phase <= tcb_lite_pkg::PH_FIRST;
        end
    end

    ////////////////////////////////////////
    // write lanes
    ////////////////////////////////////////

    // second phase works on the next word
    assign sel_hi = (phase == tcb_lite_pkg::PH_SECOND);
    assign wrd    = sel_hi ? tcb_lite_pkg::wrd_t'(op.wrd + 1'b1) : op.wrd;

    always_comb begin
        for (int i = 0; i < 2*BYT; i++) begin
            dbl_msk[i] = (i >= int'(op.lane)) && (i < int'(op.lane) + int'(op.cnt));
        end
    end

    // right-aligned data moved up to its lane
    assign dbl_wdt = {{`TCB_DAT_W{1'b0}}, op.wdt} << {op.lane, 3'b000};

    always_ff @(posedge tcb) begin
        if (acc && op.wen) begin
            for (int i = 0; i < BYT; i++) begin
                if (sel_hi ? dbl_msk[BYT+i] : dbl_msk[i]) begin
                    mem[wrd][8*i+:8] <= sel_hi ? dbl_wdt[`TCB_DAT_W+8*i+:8]
                                               : dbl_wdt[8*i+:8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // registered result
    ////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (rst) begin
            res.trn <= 1'b0;
        end else begin
            // one cycle pulse after each handshake
            res.trn <= hsk;
        end
        // transfer attributes
        if (hsk) begin
            res.wen  <= op.wen;
            res.err  <= op.err;
            res.lane <= op.lane;
            res.cnt  <= op.cnt;
        end
        // read words
        if (acc && !sel_hi) begin
            res.lo <= mem[wrd];
        end
        if (acc && sel_hi) begin
            res.hi <= mem[wrd];
        end
    end

endmodule

/* src/tcb_lite_mem_top.sv */
/*
 * Top level of the TCB-Lite memory target.
 * Chains decode, execute and result on the bus, with the protocol monitor
 * observing the same request side.
 */

`timescale 1ns/1ps

module tcb_lite_mem_top (
    input  logic                    tcb,
    input  logic                    rst,
    // request
    input  logic                    vld,
    input  tcb_lite_pkg::tcb_req_t  req,
    output logic                    rdy,
    // response, one cycle after handshake
    output tcb_lite_pkg::tcb_rsp_t  rsp,
    output logic                    rsp_vld,
    // sticky protocol flags
    output tcb_lite_pkg::tcb_viol_t viol
);

    ////////////////////////////////////////
    // stage links
    ////////////////////////////////////////

    tcb_lite_pkg::dec_op_t  op;
    tcb_lite_pkg::exe_res_t res;

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    tcb_lite_decode u_decode (
        .req (req),
        .op  (op)
    );

    tcb_lite_execute u_execute (
        .tcb (tcb),
        .rst (rst),
        .vld (vld),
        .op  (op),
        .rdy (rdy),
        .res (res)
    );

    tcb_lite_result u_result (
        .res     (res),
        .rsp     (rsp),
        .rsp_vld (rsp_vld)
    );

    ////////////////////////////////////////
    // bus observer
    ////////////////////////////////////////

    tcb_lite_protocol_monitor u_monitor (
        .tcb  (tcb),
        .rst  (rst),
        .vld  (vld),
        .rdy  (rdy),
        .req  (req),
        .viol (viol)
    );

endmodule

/* src/tcb_lite_params.svh */
/*
 * Width and memory-size macros for the TCB-Lite memory target.
 * Included by the package, the decoder and the execute stage.
 */

`ifndef TCB_LITE_PARAMS_SVH
`define TCB_LITE_PARAMS_SVH

// bus widths
`define TCB_ADR_W 32
`define TCB_DAT_W 32
// size code selects 1, 2 or 4 bytes
`define TCB_SIZ_W 2

// memory is 1 KiB, 256 words of 32 bits
`define TCB_MEM_BYTES 1024
`define TCB_WRD_W 8

`endif

/* src/tcb_lite_pkg.sv */
/*
 * Shared types for the TCB-Lite memory target.
 * Vector typedefs, bus request and response, internal stage structs,
 * monitor violation flags and the execute phase enum.
 */

`include "tcb_lite_params.svh"

package tcb_lite_pkg;

    ////////////////////////////////////////
    // vectors with a meaning
    ////////////////////////////////////////

    typedef logic [`TCB_ADR_W-1:0] adr_t;
    typedef logic [`TCB_DAT_W-1:0] dat_t;
    // transfer moves 2**siz bytes
    typedef logic [`TCB_SIZ_W-1:0] siz_t;
    typedef logic [`TCB_WRD_W-1:0] wrd_t;
    typedef logic [1:0]            lane_t;
    // 1 to 4 bytes
    typedef logic [2:0]            cnt_t;

    ////////////////////////////////////////
    // bus side
    ////////////////////////////////////////

    typedef struct packed {
        logic wen;
        adr_t adr;
        siz_t siz;
        dat_t wdt;
    } tcb_req_t;

    typedef struct packed {
        dat_t rdt;
        logic err;
    } tcb_rsp_t;

    ////////////////////////////////////////
    // between stages
    ////////////////////////////////////////

    typedef struct packed {
        logic  wen;
        wrd_t  wrd;
        lane_t lane;
        cnt_t  cnt;
        logic  split;
        logic  err;
        dat_t  wdt;
    } dec_op_t;

    typedef struct packed {
        logic  trn;
        logic  wen;
        logic  err;
        lane_t lane;
        cnt_t  cnt;
        dat_t  lo;
        dat_t  hi;
    } exe_res_t;

    // sticky monitor flags
    typedef struct packed {
        logic vld_rst;
        logic vld_rel;
        logic unstable;
        logic siz_rng;
    } tcb_viol_t;

    typedef enum logic {
        PH_FIRST,
        PH_SECOND
    } phase_t;

endpackage

/* src/tcb_lite_protocol_monitor.sv */
/*
 * Synthesizable TCB-Lite protocol monitor.
 * Watches the request side of the bus and raises sticky violation flags,
 * cleared by reset, for reset, stall stability and size range rules.
 */

`timescale 1ns/1ps

module tcb_lite_protocol_monitor (
    input  logic                    tcb,
    input  logic                    rst,
    input  logic                    vld,
    input  logic                    rdy,
    input  tcb_lite_pkg::tcb_req_t  req,
    output tcb_lite_pkg::tcb_viol_t viol
);

    // largest legal size code, log2 of bytes per word
    localparam int unsigned SIZ_MAX = $clog2($bits(tcb_lite_pkg::dat_t) / 8);

    ////////////////////////////////////////
    // previous bus state
    ////////////////////////////////////////

    logic                   prv_vld;
    logic                   prv_rdy;
    logic                   prv_rst;
    tcb_lite_pkg::tcb_req_t prv_req;

    always_ff @(posedge tcb) begin
        prv_vld <= vld;
        prv_rdy <= rdy;
        prv_rst <= rst;
        prv_req <= req;
    end

    ////////////////////////////////////////
    // valid during reset
    ////////////////////////////////////////

    // restarts on reset entry, then survives release
    always_ff @(posedge tcb) begin
        if (rst) begin
            viol.vld_rst <= vld | (viol.vld_rst & prv_rst);
        end
    end

    ////////////////////////////////////////
    // flags cleared by reset
    ////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (rst) begin
            viol.vld_rel  <= 1'b0;
            viol.unstable <= 1'b0;
            viol.siz_rng  <= 1'b0;
        end else begin
            // first cycle after release
            if (prv_rst && vld) begin
                viol.vld_rel <= 1'b1;
            end
            // stalled request must stay put
            if (prv_vld && !prv_rdy && vld && (req != prv_req)) begin
                viol.unstable <= 1'b1;
            end
            if (vld && (int'(req.siz) > SIZ_MAX)) begin
                viol.siz_rng <= 1'b1;
            end
        end
    end

endmodule

/* src/tcb_lite_result.sv */
/*
 * Result stage of the TCB-Lite memory target.
 * Combinational, aligns the registered read words into the response
 * read data and forwards the error and response valid.
 */

`timescale 1ns/1ps

module tcb_lite_result (
    input  tcb_lite_pkg::exe_res_t res,
    output tcb_lite_pkg::tcb_rsp_t rsp,
    output logic                   rsp_vld
);

    localparam int DW  = $bits(tcb_lite_pkg::dat_t);
    localparam int BYT = DW / 8;

    ////////////////////////////////////////
    // internal signals
    ////////////////////////////////////////

    // both words, first word in the low half
    logic [2*DW-1:0] dbl;
    logic [2*DW-1:0] dbl_sh;

    tcb_lite_pkg::dat_t rdt_sz;

    logic rd_ok;

    ////////////////////////////////////////
    // alignment
    ////////////////////////////////////////

    assign dbl    = {res.hi, res.lo};
    // starting lane moves to byte 0
    assign dbl_sh = dbl >> {res.lane, 3'b000};

    // keep cnt bytes, upper ones zero
    always_comb begin
        for (int i = 0; i < BYT; i++) begin
            rdt_sz[8*i+:8] = (i < int'(res.cnt)) ? dbl_sh[8*i+:8] : 8'h00;
        end
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////

    // writes and errors return zero data
    assign rd_ok = ~res.wen & ~res.err;

    always_comb begin
        rsp.rdt = rd_ok ? rdt_sz : '0;
        rsp.err = res.err;
    end

    assign rsp_vld = res.trn;

endmodule

/* tb.f */
+incdir+src
src/tcb_lite_pkg.sv
src/tcb_lite_decode.sv
src/tcb_lite_execute.sv
src/tcb_lite_result.sv
src/tcb_lite_protocol_monitor.sv
src/tcb_lite_mem_top.sv
verification/tcb_lite_mem_tb.sv

/* verification/tcb_lite_mem_tb.sv */
/*
 * Table-driven testbench of the TCB-Lite memory target.
 * Applies each table row over the bus, compares the response and the
 * monitor flags against a byte-array model, with a watchdog on the run.
 */

`timescale 1ns/1ps

`include "tcb_lite_params.svh"

module tcb_lite_mem_tb;

    localparam int RST_CYCLES = 10;
    localparam logic [31:0] SEED = 32'd85957;

    typedef enum logic [2:0] {
        K_IDLE,
        K_WRITE,
        K_READ,
        K_RESET,
        K_REL,
        K_UNSTABLE
    } kind_t;

    // one table row
    // alt is the address swapped in during a stall
    typedef struct packed {
        kind_t               kind;
        tcb_lite_pkg::adr_t  adr;
        tcb_lite_pkg::adr_t  alt;
        tcb_lite_pkg::siz_t  siz;
        logic                rnd;
        logic                err;
        logic [3:0]          viol;
    } row_t;

    ////////////////////////////////////////
    // DUT and clock
    ////////////////////////////////////////

    logic                    tcb;
    logic                    rst;
    logic                    vld;
    tcb_lite_pkg::tcb_req_t  req;
    logic                    rdy;
    tcb_lite_pkg::tcb_rsp_t  rsp;
    logic                    rsp_vld;
    tcb_lite_pkg::tcb_viol_t viol;

    tcb_lite_mem_top dut (
        .tcb     (tcb),
        .rst     (rst),
        .vld     (vld),
        .req     (req),
        .rdy     (rdy),
        .rsp     (rsp),
        .rsp_vld (rsp_vld),
        .viol    (viol)
    );

    always #5 tcb = ~tcb;

    ////////////////////////////////////////
    // table, model and LFSR state
    ////////////////////////////////////////

    row_t        rows[$];
    string       names[$];
    logic [7:0]  model [0:`TCB_MEM_BYTES-1];
    logic [31:0] lfsr;
    logic        table_ready;

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s %s expected %h actual %h", test, field, exp, act);
            report_failure();
        end
    endtask

    // taps of x^32 + x^22 + x^2 + x + 1
    // one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // right-aligned random bytes with upper bytes zero
    function automatic tcb_lite_pkg::dat_t random_data(input int cnt);
        tcb_lite_pkg::dat_t d;
        d = '0;
        for (int i = 0; i < 8*cnt; i++) begin
            d[i] = lfsr_bit();
        end
        return d;
    endfunction

    function automatic int byte_count(input tcb_lite_pkg::siz_t siz);
        return 1 << siz;
    endfunction

    // bad size code or any byte past the memory end
    function automatic logic range_error(input tcb_lite_pkg::adr_t adr,
                                         input tcb_lite_pkg::siz_t siz);
        logic [63:0] last;
        last = {32'b0, adr} + 64'(byte_count(siz));
        return (siz == 2'd3) || (last > 64'(`TCB_MEM_BYTES));
    endfunction

    function automatic tcb_lite_pkg::dat_t model_read(input tcb_lite_pkg::adr_t adr,
                                                      input int cnt);
        tcb_lite_pkg::dat_t d;
        d = '0;
        for (int i = 0; i < cnt; i++) begin
            d[8*i+:8] = model[int'(adr) + i];
        end
        return d;
    endfunction

    task automatic add_row(input string name, input kind_t kind,
                           input tcb_lite_pkg::adr_t adr, input tcb_lite_pkg::adr_t alt,
                           input tcb_lite_pkg::siz_t siz, input logic rnd,
                           input logic err, input logic [3:0] viol_exp);
        row_t r;
        r.kind = kind;
        r.adr  = adr;
        r.alt  = alt;
        r.siz  = siz;
        r.rnd  = rnd;
        r.err  = err;
        r.viol = viol_exp;
        rows.push_back(r);
        names.push_back(name);
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    // viol bits in order vld_rst vld_rel unstable siz_rng
    task automatic build_table();
        add_row("idle_after_rst", K_IDLE,     32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0000);
        // aligned 1, 2 and 4 bytes
        add_row("wr_b0",          K_WRITE,    32'h000, 32'h0, 2'd0, 1'b1, 1'b0, 4'b0000);
        add_row("wr_b1",          K_WRITE,    32'h001, 32'h0, 2'd0, 1'b1, 1'b0, 4'b0000);
        add_row("wr_h2",          K_WRITE,    32'h002, 32'h0, 2'd1, 1'b1, 1'b0, 4'b0000);
        add_row("wr_w4",          K_WRITE,    32'h004, 32'h0, 2'd2, 1'b1, 1'b0, 4'b0000);
        add_row("rd_b0",          K_READ,     32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0000);
        add_row("rd_h2",          K_READ,     32'h002, 32'h0, 2'd1, 1'b0, 1'b0, 4'b0000);
        add_row("rd_w4",          K_READ,     32'h004, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        add_row("rd_w0",          K_READ,     32'h000, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        add_row("wr_w8",          K_WRITE,    32'h008, 32'h0, 2'd2, 1'b1, 1'b0, 4'b0000);
        add_row("wr_wc",          K_WRITE,    32'h00c, 32'h0, 2'd2, 1'b1, 1'b0, 4'b0000);
        add_row("wr_w10",         K_WRITE,    32'h010, 32'h0, 2'd2, 1'b1, 1'b0, 4'b0000);
        // word boundary crossings
        add_row("wr_split_w",     K_WRITE,    32'h00e, 32'h0, 2'd2, 1'b1, 1'b0, 4'b0000);
        add_row("wr_split_h",     K_WRITE,    32'h013, 32'h0, 2'd1, 1'b1, 1'b0, 4'b0000);
        add_row("rd_split_w",     K_READ,     32'h00e, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        add_row("rd_split_h",     K_READ,     32'h013, 32'h0, 2'd1, 1'b0, 1'b0, 4'b0000);
        add_row("rd_split_w3",    K_READ,     32'h00b, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        // top of memory and range errors
        add_row("wr_top_h",       K_WRITE,    32'h3fe, 32'h0, 2'd1, 1'b1, 1'b0, 4'b0000);
        add_row("wr_last_h",      K_WRITE,    32'h3fc, 32'h0, 2'd1, 1'b1, 1'b0, 4'b0000);
        add_row("err_wr_over",    K_WRITE,    32'h3fe, 32'h0, 2'd2, 1'b0, 1'b1, 4'b0000);
        add_row("err_rd_over",    K_READ,     32'h3fe, 32'h0, 2'd2, 1'b0, 1'b1, 4'b0000);
        add_row("rd_top_kept",    K_READ,     32'h3fe, 32'h0, 2'd1, 1'b0, 1'b0, 4'b0000);
        add_row("err_wr_far",     K_WRITE,    32'h400, 32'h0, 2'd0, 1'b0, 1'b1, 4'b0000);
        add_row("rd_b0_kept",     K_READ,     32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0000);
        add_row("err_rd_wrap",    K_READ,     32'hffff_fffe, 32'h0, 2'd2, 1'b0, 1'b1, 4'b0000);
        add_row("rd_last_w",      K_READ,     32'h3fc, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        // protocol violations whose flags stick until reset
        add_row("viol_siz3",      K_READ,     32'h000, 32'h0, 2'd3, 1'b0, 1'b1, 4'b0001);
        add_row("idle_siz3",      K_IDLE,     32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0001);
        add_row("viol_unstable",  K_UNSTABLE, 32'h00e, 32'h00d, 2'd2, 1'b0, 1'b0, 4'b0011);
        add_row("viol_release",   K_REL,      32'h004, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0100);
        add_row("idle_release",   K_IDLE,     32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0100);
        // clean sequence after reset
        add_row("reset_clear",    K_RESET,    32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0000);
        add_row("rd_w8_clean",    K_READ,     32'h008, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        add_row("rd_split_clean", K_READ,     32'h011, 32'h0, 2'd2, 1'b0, 1'b0, 4'b0000);
        add_row("idle_end",       K_IDLE,     32'h000, 32'h0, 2'd0, 1'b0, 1'b0, 4'b0000);
    endtask

    ////////////////////////////////////////
    // driver
    ////////////////////////////////////////

    // ends on the falling edge where rst is released
    task automatic pulse_reset(input string test);
        @(negedge tcb);
        rst = 1'b1;
        repeat (3) begin
            @(negedge tcb);
            check_value(test, "rsp_vld in reset", 32'd0, {31'b0, rsp_vld});
        end
        rst = 1'b0;
    endtask

    task automatic drive_transfer(input int idx, input bit at_edge);
        row_t               r;
        string              nm;
        int                 cnt;
        int                 stalls;
        logic               err_exp;
        logic               split_exp;
        tcb_lite_pkg::dat_t wdt;
        tcb_lite_pkg::dat_t rdt_exp;
        tcb_lite_pkg::adr_t adr_rd;
        r   = rows[idx];
        nm  = names[idx];
        cnt = byte_count(r.siz);
        err_exp = range_error(r.adr, r.siz);
        assert (err_exp === r.err) else begin
            $display("table row %s disagrees with the size and range rules", nm);
            report_failure();
        end
        split_exp = !err_exp && (int'(r.adr[1:0]) + cnt > 4);
        // fixed pattern from the whole address when no LFSR data is asked
        wdt = r.rnd ? random_data(cnt) : ~r.adr;
        // a stalled address swap ends up reading from the new address
        adr_rd  = (r.kind == K_UNSTABLE) ? r.alt : r.adr;
        rdt_exp = (r.kind != K_WRITE && !err_exp) ? model_read(adr_rd, cnt) : '0;
        if (!at_edge) begin
            @(negedge tcb);
        end
        check_value(nm, "rsp_vld before request", 32'd0, {31'b0, rsp_vld});
        vld     = 1'b1;
        req.wen = (r.kind == K_WRITE);
        req.adr = r.adr;
        req.siz = r.siz;
        req.wdt = wdt;
        stalls  = 0;
        #1;
        while (!rdy) begin
            stalls++;
            @(negedge tcb);
            check_value(nm, "rsp_vld in stall", 32'd0, {31'b0, rsp_vld});
            if (r.kind == K_UNSTABLE) begin
                req.adr = r.alt;
            end
            #1;
        end
        // handshake edge passes here
        @(negedge tcb);
        assert (rsp_vld === 1'b1) else begin
            $display("%s got no response in the cycle after its handshake", nm);
            report_failure();
        end
        vld = 1'b0;
        req = '0;
        check_value(nm, "stall cycles", split_exp ? 32'd1 : 32'd0, stalls);
        check_value(nm, "err", {31'b0, err_exp}, {31'b0, rsp.err});
        check_value(nm, "rdt", rdt_exp, rsp.rdt);
        check_value(nm, "viol", {28'b0, r.viol}, {28'b0, viol});
        if (r.kind == K_WRITE && !err_exp) begin
            for (int i = 0; i < cnt; i++) begin
                model[int'(r.adr) + i] = wdt[8*i+:8];
            end
        end
    endtask

    task automatic run_row(input int idx);
        case (rows[idx].kind)
            K_IDLE: begin
                @(negedge tcb);
                check_value(names[idx], "rsp_vld", 32'd0, {31'b0, rsp_vld});
                check_value(names[idx], "viol", {28'b0, rows[idx].viol}, {28'b0, viol});
            end
            K_RESET: begin
                pulse_reset(names[idx]);
                @(negedge tcb);
                check_value(names[idx], "rsp_vld", 32'd0, {31'b0, rsp_vld});
                check_value(names[idx], "viol", {28'b0, rows[idx].viol}, {28'b0, viol});
            end
            K_REL: begin
                // valid goes up on the same edge as the release
                pulse_reset(names[idx]);
                drive_transfer(idx, 1'b1);
            end
            default: begin
                drive_transfer(idx, 1'b0);
            end
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        tcb         = 1'b0;
        rst         = 1'b1;
        vld         = 1'b0;
        req         = '0;
        lfsr        = SEED;
        table_ready = 1'b0;
        for (int i = 0; i < `TCB_MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) begin
            @(negedge tcb);
            check_value("reset", "rsp_vld in reset", 32'd0, {31'b0, rsp_vld});
        end
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("No errors");
        $finish;
    end

    // 8 cycles per row is well above the longest row
    initial begin
        wait (table_ready);
        repeat (rows.size() * 8 + RST_CYCLES) @(posedge tcb);
        $display("timeout, the table did not complete in %0d cycles",
                 rows.size() * 8 + RST_CYCLES);
        report_failure();
    end

endmodule
